//--- hdl/sprite_pkg.sv
////////////////////////////////////////////////////////////
// sprite command package
// opcode and FSM state enums, field widths and the packed
// structs carried between decoder, control unit and storage
////////////////////////////////////////////////////////////
package sprite_pkg;

	////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////
	localparam int OPC_W        = 4;                    // opcode field, instr[3:0]
	localparam int SPRITE_IDX_W = 5;                    // sprite index, instr[8:4]
	localparam int MEM_ADDR_W   = 14;                   // pattern address, instr[13:0]
	localparam int DATA_W       = 32;                   // operand and stored word width
	localparam int NUM_SPRITES  = 1 << SPRITE_IDX_W;    // 32 sprite slots
	localparam int MEM_WORDS    = 1 << MEM_ADDR_W;      // 16 K colour words

	// host opcodes, 3 is a no-operation
	typedef enum logic [OPC_W-1:0] {
		OP_POS    = 4'd0,                           // sprite x/y position
		OP_MEM_WR = 4'd1,                           // pattern memory word
		OP_OFFSET = 4'd2,                           // sprite memory offset
		OP_NOP    = 4'd3,
		OP_IDLE   = 4'd15                           // nothing valid or unknown opcode
	} op_t;

	typedef enum logic {
		CTRL_RUN,                                   // accepting decoded commands
		CTRL_MEM_WAIT                               // slow memory write in progress
	} ctrl_state_t;

	////////////////////////////////////////////////////////////
	// stage payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                  valid;
		op_t                   op;
		logic [MEM_ADDR_W-1:0] target;              // zero-extended index or address
		logic [DATA_W-1:0]     data;
	} decoded_cmd_t;

	typedef struct packed {
		logic                    en;
		logic                    sel_offset;        // 1 offset array, 0 position array
		logic [SPRITE_IDX_W-1:0] idx;
		logic [DATA_W-1:0]       data;
	} reg_wr_t;

	typedef struct packed {
		logic                  en;
		logic [MEM_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     data;
	} mem_wr_t;

endpackage

//--- hdl/instr_decoder.sv
////////////////////////////////////////////////////////////
// instruction decoder, pipeline stage 1
// splits a strobed host instruction into opcode, target and
// data fields; strobes seen while busy are dropped
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_decoder (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [sprite_pkg::DATA_W-1:0] instr,
	input  logic [sprite_pkg::DATA_W-1:0] operand,
	input  logic                        instr_strobe,
	input  logic                        busy,
	output sprite_pkg::decoded_cmd_t    cmd
);
	import sprite_pkg::*;

	decoded_cmd_t cmd_d;                                    // next stage contents
	logic         accept;

	assign accept = instr_strobe && !busy;                  // host must wait out busy

	always_comb begin
		cmd_d = '{valid: 1'b0, op: OP_IDLE, target: '0, data: '0};  // idle slot
		if (accept) begin
			case (instr[OPC_W-1:0])
				OP_POS: begin
					cmd_d.valid  = 1'b1;
					cmd_d.op     = OP_POS;
					cmd_d.target = MEM_ADDR_W'(instr[OPC_W +: SPRITE_IDX_W]); // sprite idx
					cmd_d.data   = operand;                 // packed x and y
				end
				OP_MEM_WR: begin
					cmd_d.valid  = 1'b1;
					cmd_d.op     = OP_MEM_WR;
					cmd_d.target = instr[MEM_ADDR_W-1:0];   // full word address
					cmd_d.data   = operand;                 // colour word
				end
				OP_OFFSET: begin
					cmd_d.valid  = 1'b1;
					cmd_d.op     = OP_OFFSET;
					cmd_d.target = MEM_ADDR_W'(instr[OPC_W +: SPRITE_IDX_W]);
					cmd_d.data   = operand;                 // base offset into pattern mem
				end
				OP_NOP: begin
					cmd_d.valid = 1'b1;                     // passes down, writes nothing
					cmd_d.op    = OP_NOP;
				end
				default: ;                                  // unknown opcode stays idle
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cmd <= '{valid: 1'b0, op: OP_IDLE, target: '0, data: '0};
		end else begin
			cmd <= cmd_d;                                   // one slot per clock
		end
	end

endmodule

//--- hdl/cmd_control.sv
////////////////////////////////////////////////////////////
// command control unit, pipeline stage 2
// turns decoded commands into register bank or pattern
// memory write requests and raises busy for memory writes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cmd_control #(
	parameter int MEM_WR_CYCLES = 3                     // busy cycles held by a memory write
) (
	input  logic                     clk,
	input  logic                     reset,
	input  sprite_pkg::decoded_cmd_t cmd,
	output sprite_pkg::reg_wr_t      reg_wr,
	output sprite_pkg::mem_wr_t      mem_wr,
	output logic                     busy
);
	import sprite_pkg::*;

	localparam int CNT_W = $clog2(MEM_WR_CYCLES + 1);

	ctrl_state_t      state;
	logic [CNT_W-1:0] wait_cnt;                         // remaining memory wait cycles
	logic             mem_cmd;                          // memory write sitting in stage 1

	assign mem_cmd = cmd.valid && (cmd.op == OP_MEM_WR);

	// first busy cycle comes from stage 1, the rest from the wait state
	assign busy = mem_cmd || (state == CTRL_MEM_WAIT);

	////////////////////////////////////////////////////////////
	// control FSM and write request registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= CTRL_RUN;
			wait_cnt <= '0;
			reg_wr   <= '0;
			mem_wr   <= '0;
		end else begin
			reg_wr.en <= 1'b0;                          // requests last one cycle
			mem_wr.en <= 1'b0;
			case (state)
				CTRL_RUN: begin
					if (cmd.valid) begin
						case (cmd.op)
							OP_POS, OP_OFFSET: begin
								reg_wr.en         <= 1'b1;
								reg_wr.sel_offset <= (cmd.op == OP_OFFSET);
								reg_wr.idx        <= cmd.target[SPRITE_IDX_W-1:0];
								reg_wr.data       <= cmd.data;
							end
							OP_MEM_WR: begin
								mem_wr.en   <= 1'b1;
								mem_wr.addr <= cmd.target;
								mem_wr.data <= cmd.data;
								wait_cnt    <= CNT_W'(MEM_WR_CYCLES - 1);
								state       <= CTRL_MEM_WAIT;
							end
							default: ;                  // nop, no write
						endcase
					end
				end
				CTRL_MEM_WAIT: begin
					if (wait_cnt == '0) begin
						state <= CTRL_RUN;              // busy drops after this edge
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: state <= CTRL_RUN;
			endcase
		end
	end

endmodule

//--- hdl/sprite_reg_bank.sv
////////////////////////////////////////////////////////////
// sprite register bank, pipeline stage 3a
// 32 sprite slots, each with a position word and a pattern
// memory offset; read port is combinational
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sprite_reg_bank (
	input  logic                              clk,
	input  logic                              reset,
	input  sprite_pkg::reg_wr_t               reg_wr,
	input  logic [sprite_pkg::SPRITE_IDX_W-1:0] rd_idx,
	output logic [sprite_pkg::DATA_W-1:0]     rd_pos,
	output logic [sprite_pkg::DATA_W-1:0]     rd_offset
);
	import sprite_pkg::*;

	logic [DATA_W-1:0] pos_q    [NUM_SPRITES];      // x/y of each sprite
	logic [DATA_W-1:0] offset_q [NUM_SPRITES];      // pattern base per sprite

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < NUM_SPRITES; i++) begin
				pos_q[i]    <= '0;                      // all sprites parked at origin
				offset_q[i] <= '0;
			end
		end else if (reg_wr.en) begin
			if (reg_wr.sel_offset) begin
				offset_q[reg_wr.idx] <= reg_wr.data;
			end else begin
				pos_q[reg_wr.idx] <= reg_wr.data;
			end
		end
	end

	// read side, same cycle as the index
	assign rd_pos    = pos_q[rd_idx];
	assign rd_offset = offset_q[rd_idx];

endmodule

//--- hdl/sprite_memory.sv
////////////////////////////////////////////////////////////
// sprite pattern memory, pipeline stage 3b
// 16 K colour words behind a slow write path; a write waits
// in a pending register until the modelled delay expires
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sprite_memory #(
	parameter int MEM_WR_CYCLES = 3                 // modelled write time in cycles
) (
	input  logic                              clk,
	input  logic                              reset,
	input  sprite_pkg::mem_wr_t               mem_wr,
	input  logic [sprite_pkg::MEM_ADDR_W-1:0] rd_addr,
	output logic [sprite_pkg::DATA_W-1:0]     rd_color
);
	import sprite_pkg::*;

	localparam int DELAY = MEM_WR_CYCLES - 1;       // edges from latch to commit
	localparam int CNT_W = $clog2(MEM_WR_CYCLES + 1);

	logic [DATA_W-1:0] mem [MEM_WORDS];
	mem_wr_t           pend;                        // write waiting for the slow array
	logic [CNT_W-1:0]  pend_cnt;

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) mem[i] = '0;  // blank patterns at power up
	end

	////////////////////////////////////////////////////////////
	// pending write and commit counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pend     <= '0;
			pend_cnt <= '0;
		end else if (mem_wr.en && DELAY > 0) begin
			pend     <= mem_wr;                     // latch, commit later
			pend_cnt <= CNT_W'(DELAY);
		end else if (pend.en) begin
			pend_cnt <= pend_cnt - 1'b1;
			if (pend_cnt == 1) pend.en <= 1'b0;     // committed this edge
		end
	end

	// array write and registered read port
	always_ff @(posedge clk) begin
		if (mem_wr.en && DELAY == 0) begin
			mem[mem_wr.addr] <= mem_wr.data;        // single cycle model writes through
		end else if (pend.en && pend_cnt == 1) begin
			mem[pend.addr] <= pend.data;
		end
		rd_color <= mem[rd_addr];                   // one cycle after the address
	end

endmodule

//--- hdl/sprite_cmd_top.sv
////////////////////////////////////////////////////////////
// sprite command front end, top level
// decoder, control unit, register bank and pattern memory
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sprite_cmd_top #(
	parameter int MEM_WR_CYCLES = 3                 // pattern memory write time
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [sprite_pkg::DATA_W-1:0]       instr,
	input  logic [sprite_pkg::DATA_W-1:0]       operand,
	input  logic                                instr_strobe,
	input  logic [sprite_pkg::SPRITE_IDX_W-1:0] rd_idx,
	input  logic [sprite_pkg::MEM_ADDR_W-1:0]   rd_addr,
	output logic                                busy,
	output logic [sprite_pkg::DATA_W-1:0]       rd_pos,
	output logic [sprite_pkg::DATA_W-1:0]       rd_offset,
	output logic [sprite_pkg::DATA_W-1:0]       rd_color
);
	import sprite_pkg::*;

	decoded_cmd_t cmd;                              // stage 1 -> stage 2
	reg_wr_t      reg_wr;                           // stage 2 -> register bank
	mem_wr_t      mem_wr;                           // stage 2 -> pattern memory

	instr_decoder u_decoder (
		.clk(clk), .reset(reset),
		.instr(instr), .operand(operand), .instr_strobe(instr_strobe),
		.busy(busy), .cmd(cmd)
	);

	cmd_control #(.MEM_WR_CYCLES(MEM_WR_CYCLES)) u_control (
		.clk(clk), .reset(reset), .cmd(cmd),
		.reg_wr(reg_wr), .mem_wr(mem_wr), .busy(busy)
	);

	sprite_reg_bank u_reg_bank (
		.clk(clk), .reset(reset), .reg_wr(reg_wr),
		.rd_idx(rd_idx), .rd_pos(rd_pos), .rd_offset(rd_offset)
	);

	sprite_memory #(.MEM_WR_CYCLES(MEM_WR_CYCLES)) u_memory (
		.clk(clk), .reset(reset), .mem_wr(mem_wr),
		.rd_addr(rd_addr), .rd_color(rd_color)
	);

endmodule

//--- tb/sprite_cmd_props.sv
////////////////////////////////////////////////////////////
// control unit properties
// write requests only follow accepted commands, busy
// covers memory writes and never goes unknown
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sprite_cmd_props (
	input logic                     clk,
	input logic                     reset,
	input sprite_pkg::decoded_cmd_t cmd,
	input sprite_pkg::reg_wr_t      reg_wr,
	input sprite_pkg::mem_wr_t      mem_wr,
	input logic                     busy,
	input sprite_pkg::ctrl_state_t  state
);
	import sprite_pkg::*;

	int fail_count = 0;                                 // failed assertions so far

	a_busy_known: assert property (@(posedge clk) !$isunknown(busy)) else begin
		fail_count++;
		$error("busy is unknown");
	end

	a_reset_quiet: assert property (@(posedge clk) !reset |-> !reg_wr.en && !mem_wr.en) else begin
		fail_count++;
		$error("write enable high during reset");
	end

	// register write only one cycle after a decoded position or offset
	a_reg_src: assert property (@(posedge clk) disable iff (!reset)
		reg_wr.en |-> $past(cmd.valid && (cmd.op == OP_POS || cmd.op == OP_OFFSET))) else begin
		fail_count++;
		$error("register write without an accepted command");
	end

	a_mem_src: assert property (@(posedge clk) disable iff (!reset)
		mem_wr.en |-> $past(cmd.valid && cmd.op == OP_MEM_WR) && busy) else begin
		fail_count++;
		$error("memory write without an accepted command or without busy");
	end

	a_idle_no_wr: assert property (@(posedge clk) disable iff (!reset)
		(!cmd.valid || cmd.op == OP_NOP) |=> !reg_wr.en && !mem_wr.en) else begin
		fail_count++;
		$error("write request after a nop or idle slot");
	end

	// busy only rises with a memory write sitting in stage 1
	a_idle_busy: assert property (@(posedge clk) disable iff (!reset)
		$rose(busy) |-> cmd.valid && cmd.op == OP_MEM_WR) else begin
		fail_count++;
		$error("busy raised without a memory write");
	end

endmodule

bind cmd_control sprite_cmd_props u_props (
	.clk(clk), .reset(reset), .cmd(cmd),
	.reg_wr(reg_wr), .mem_wr(mem_wr), .busy(busy), .state(state)
);

//--- tb/sprite_cmd_tb.sv
////////////////////////////////////////////////////////////
// sprite command front end testbench
// random host commands against a model of the sprite
// registers and pattern memory, checked through read-back
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sprite_cmd_tb;
	import sprite_pkg::*;

	localparam int MEM_WR_CYCLES = 3;
	localparam int NUM_CMDS      = 300;
	localparam int TIMEOUT       = 40;                  // cycles allowed for any wait

	logic                    clk, reset, instr_strobe, busy;
	logic [DATA_W-1:0]       instr, operand, rd_pos, rd_offset, rd_color;
	logic [SPRITE_IDX_W-1:0] rd_idx;
	logic [MEM_ADDR_W-1:0]   rd_addr;

	logic [DATA_W-1:0]     model_pos    [NUM_SPRITES];  // expected sprite state
	logic [DATA_W-1:0]     model_offset [NUM_SPRITES];
	logic [DATA_W-1:0]     model_mem    [MEM_WORDS];
	logic [MEM_ADDR_W-1:0] mem_touched  [$];            // addresses written so far
	integer                seed = 32'hcdfc_d9de;
	int                    errors;
	bit                    timed_out;

	sprite_cmd_top #(.MEM_WR_CYCLES(MEM_WR_CYCLES)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic compare_word(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [DATA_W-1:0] make_instr(input logic [3:0] opc);
		logic [DATA_W-1:0] w;
		w      = $random(seed);                         // junk in the unused bits
		w[3:0] = opc;
		return w;
	endfunction

	// one strobe, returns 5 ns after the edge that samples it
	task automatic strobe_instr(input logic [DATA_W-1:0] word, input logic [DATA_W-1:0] data);
		instr        = word;
		operand      = data;
		instr_strobe = 1'b1;
		@(posedge clk);
		#5;
		instr_strobe = 1'b0;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy !== 1'b0 && cycles < TIMEOUT) begin
			@(posedge clk);
			#5;
			cycles++;
		end
		if (busy !== 1'b0) begin
			timed_out = 1'b1;
			errors++;
			$display("timeout: busy did not fall within %0d cycles", cycles);
		end
	endtask

	// one index per clock
	task automatic sweep_regs();
		for (int i = 0; i < NUM_SPRITES; i++) begin
			rd_idx = SPRITE_IDX_W'(i);                  // combinational read port
			#1;
			compare_word($sformatf("rd_pos[%0d]", i), rd_pos, model_pos[i]);
			compare_word($sformatf("rd_offset[%0d]", i), rd_offset, model_offset[i]);
			@(posedge clk);
			#5;
		end
	endtask

	task automatic check_color(input logic [MEM_ADDR_W-1:0] addr);
		rd_addr = addr;
		@(posedge clk);                                 // registered read port
		#5;
		compare_word($sformatf("rd_color[%h]", addr), rd_color, model_mem[addr]);
	endtask

	// position and offset writes on consecutive cycles
	task automatic reg_burst(input int count);
		logic [DATA_W-1:0] word, data, sel;
		for (int i = 0; i < count; i++) begin
			sel  = $random(seed);
			word = make_instr(sel[0] ? OP_OFFSET : OP_POS);
			data = $random(seed);
			if (word[3:0] == OP_OFFSET) model_offset[word[8:4]] = data;
			else model_pos[word[8:4]] = data;
			strobe_instr(word, data);
			compare_word("busy", DATA_W'(busy), '0);    // register writes never stall
		end
		repeat (2) @(posedge clk);                      // last write lands at edge n+2
		#5;
	endtask

	task automatic mem_cmd(input bit junk);
		logic [DATA_W-1:0] word, data;
		int                busy_cycles;
		word = make_instr(OP_MEM_WR);
		data = $random(seed);
		strobe_instr(word, data);
		busy_cycles = 0;
		while (busy === 1'b1 && busy_cycles < TIMEOUT) begin
			busy_cycles++;
			instr        = make_instr(OP_POS);          // strobes here must be dropped
			operand      = $random(seed);
			instr_strobe = junk;
			@(posedge clk);
			#5;
			instr_strobe = 1'b0;
		end
		if (busy !== 1'b0) begin
			timed_out = 1'b1;
			errors++;
			$display("timeout: busy stayed high for %0d cycles after a memory write", busy_cycles);
		end else begin
			compare_word("busy high cycles", DATA_W'(busy_cycles), DATA_W'(MEM_WR_CYCLES + 1));
		end
		model_mem[word[MEM_ADDR_W-1:0]] = data;
		mem_touched.push_back(word[MEM_ADDR_W-1:0]);
		check_color(word[MEM_ADDR_W-1:0]);
	endtask

	// nop and unknown opcodes, busy has to stay low
	task automatic idle_cmd(input logic [3:0] opc);
		strobe_instr(make_instr(opc), $random(seed));
		repeat (2) begin
			compare_word("busy", DATA_W'(busy), '0);
			@(posedge clk);
			#5;
		end
	endtask

	initial begin
		logic [DATA_W-1:0] r;
		reset        = 1'b0;
		instr        = '0;
		operand      = '0;
		instr_strobe = 1'b0;
		rd_idx       = '0;
		rd_addr      = '0;
		errors       = 0;
		timed_out    = 1'b0;
		for (int i = 0; i < NUM_SPRITES; i++) begin
			model_pos[i]    = '0;
			model_offset[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
		repeat (16) @(posedge clk);
		#5;
		reset = 1'b1;
		compare_word("busy", DATA_W'(busy), '0);        // state after reset
		sweep_regs();
		r = $random(seed);
		check_color(r[MEM_ADDR_W-1:0]);
		for (int n = 0; n < NUM_CMDS && !timed_out; n++) begin
			r = $random(seed);
			wait_idle();
			if (!timed_out) begin
				case (r[2:0])
					3'd0, 3'd1: reg_burst(1 + int'(r[4:3]));
					3'd2, 3'd3: mem_cmd(r[5]);
					3'd4:       idle_cmd(OP_NOP);
					default:    idle_cmd(4'(4 + r[31:8] % 11));  // opcodes 4 to 14
				endcase
				sweep_regs();                           // other entries untouched
			end
		end
		foreach (mem_touched[i]) check_color(mem_touched[i]);
		$display("checks done: %0d testbench errors, %0d assertion failures",
			errors, uut.u_control.u_props.fail_count);
		if (errors == 0 && uut.u_control.u_props.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- sources.f
hdl/sprite_pkg.sv
hdl/instr_decoder.sv
hdl/cmd_control.sv
hdl/sprite_reg_bank.sv
hdl/sprite_memory.sv
hdl/sprite_cmd_top.sv
tb/sprite_cmd_props.sv
tb/sprite_cmd_tb.sv

//--- run.sh
#!/bin/bash
# build the sprite command testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module sprite_cmd_tb -f sources.f \
	-o sprite_cmd_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sprite_cmd_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; } \
	|| echo "simulation passed"
